//--- common/audio_pkg.sv
/*
 * Audio sample formats
 * Source sample types, mix accumulator and output sample
 * Clamp limits of the output sample
 */
package audio_pkg;

	// Widths of each audio path
	localparam int fm_width  = 16;
	localparam int psg_width = 8;
	localparam int out_width = 16;

	// One guard bit over the output range
	localparam int sum_width = out_width + 1;

	// FM synthesizer output, two's complement
	typedef logic signed [fm_width-1:0]  fm_sample_t;

	// Tandy sound chip level, unsigned
	typedef logic        [psg_width-1:0] psg_code_t;

	// Accumulator for the three-way sum
	typedef logic signed [sum_width-1:0] mix_sum_t;

	// Final mono sample
	typedef logic signed [out_width-1:0] audio_sample_t;

	//////////////////////////////////////////////////
	// Clamp limits
	//////////////////////////////////////////////////

	localparam audio_sample_t sample_max = 16'h7FFF;
	localparam audio_sample_t sample_min = 16'h8000;

endpackage

//--- common/audio_cfg_pkg.sv
/*
 * User audio settings
 * Volume and compressor mode types
 * Fixed light and heavy compression curve constants
 */
package audio_cfg_pkg;

	// Each step doubles the source level
	typedef logic [1:0] volume_t;

	// 0 bypass, 1 light, 2 and 3 heavy
	typedef logic [1:0] comp_mode_t;

	localparam comp_mode_t comp_bypass = 2'd0;
	localparam comp_mode_t comp_light  = 2'd1;

	//////////////////////////////////////////////////
	// Light curve
	//////////////////////////////////////////////////

	localparam logic [15:0] comp_light_gain = 16'd2;
	localparam logic [15:0] comp_light_fall = 16'd4;

	// Knee where the gain slope meets the fall slope, rounded up
	localparam logic [15:0] comp_light_knee =
		16'((32767 * (comp_light_fall - 1)) / (comp_light_fall * comp_light_gain - 1) + 1);

	localparam logic [15:0] comp_light_base = 16'(comp_light_knee * comp_light_gain);

	//////////////////////////////////////////////////
	// Heavy curve
	//////////////////////////////////////////////////

	localparam logic [15:0] comp_heavy_gain = 16'd4;
	localparam logic [15:0] comp_heavy_fall = 16'd8;

	localparam logic [15:0] comp_heavy_knee =
		16'((32767 * (comp_heavy_fall - 1)) / (comp_heavy_fall * comp_heavy_gain - 1) + 1);

	localparam logic [15:0] comp_heavy_base = 16'(comp_heavy_knee * comp_heavy_gain);

endpackage

//--- audio_in/sample_sync.sv
/*
 * Stability filter for samples from slower sound clocks
 * Two capture stages and a held output register
 */
module sample_sync #(
	parameter type sample_t = logic [15:0]
) (
	input  logic    clk_chipset,
	input  logic    reset_sdram,
	input  sample_t sample_in,
	output sample_t sample_out
);

	// Capture pipeline
	sample_t capture_0;
	sample_t capture_1;

	logic stages_agree;

	assign stages_agree = (capture_0 == capture_1);

	// Output only follows once two captures match
	always_ff @(posedge clk_chipset, posedge reset_sdram) begin
		if (reset_sdram) begin
			capture_0  <= '0;
			capture_1  <= '0;
			sample_out <= '0;
		end else begin
			capture_0 <= sample_in;
			capture_1 <= capture_0;
			if (stages_agree) begin
				sample_out <= capture_1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// A new output value must be an input seen at two consecutive captures
	assert property (@(posedge clk_chipset) disable iff (reset_sdram)
		$changed(sample_out) |-> (sample_out == $past(sample_in, 3))
			&& ($past(sample_in, 2) == $past(sample_in, 3)))
	else $error("sample_sync output moved without two matching captures");

endmodule

//--- audio_in/psg_level.sv
/*
 * Tandy sound chip conditioning
 * Stability filter on the raw level
 * Volume scaling into a mix sample
 */
module psg_level
	import audio_pkg::*, audio_cfg_pkg::*;
#(
	parameter int PSG_BASE_SHIFT = 4
) (
	input  logic      clk_chipset,
	input  logic      reset_sdram,
	input  psg_code_t psg_code,
	input  volume_t   psg_volume,
	output mix_sum_t  psg_mix
);

	psg_code_t psg_stable;
	mix_sum_t  psg_wide;
	mix_sum_t  psg_scaled;

	// Level crosses from the sound chip clock
	sample_sync #(
		.sample_t (psg_code_t)
	) psg_sync (
		.clk_chipset (clk_chipset),
		.reset_sdram (reset_sdram),
		.sample_in   (psg_code),
		.sample_out  (psg_stable)
	);

	//////////////////////////////////////////////////
	// Volume scaling
	//////////////////////////////////////////////////

	// Zero extend, the chip level is never negative
	assign psg_wide = mix_sum_t'(psg_stable);

	// Base shift at volume 0, one more bit per step
	// Largest result is 255 << 7
	assign psg_scaled = psg_wide << (PSG_BASE_SHIFT + int'(psg_volume));

	always_ff @(posedge clk_chipset, posedge reset_sdram) begin
		if (reset_sdram) begin
			psg_mix <= '0;
		end else begin
			psg_mix <= psg_scaled;
		end
	end

endmodule

//--- audio_mix/sample_mixer.sv
/*
 * Three-source audio mixer
 * Speaker level scaling, 17-bit sum register
 * Saturating clamp to the 16-bit output range
 */
module sample_mixer
	import audio_pkg::*, audio_cfg_pkg::*;
#(
	parameter int SPK_BASE_LEVEL = 2048
) (
	input  logic          clk_chipset,
	input  logic          reset_sdram,
	input  fm_sample_t    fm_sample,
	input  mix_sum_t      psg_mix,
	input  logic          speaker,
	input  volume_t       spk_volume,
	output audio_sample_t mixed
);

	localparam int sum_top = $bits(mix_sum_t) - 1;

	mix_sum_t      fm_wide;
	mix_sum_t      spk_level;
	mix_sum_t      spk_term;
	mix_sum_t      mix_sum;
	audio_sample_t clamped;

	// Sign extend the FM sample
	assign fm_wide = mix_sum_t'(fm_sample);

	//////////////////////////////////////////////////
	// Speaker term
	//////////////////////////////////////////////////

	assign spk_level = mix_sum_t'(SPK_BASE_LEVEL) << spk_volume;

	// Speaker line is active low
	assign spk_term = speaker ? '0 : spk_level;

	//////////////////////////////////////////////////
	// Sum and clamp
	//////////////////////////////////////////////////

	// Top two bits differ when the sum left the 16-bit range
	assign clamped = (mix_sum[sum_top] ^ mix_sum[sum_top-1]) ?
		(mix_sum[sum_top] ? sample_min : sample_max) :
		audio_sample_t'(mix_sum);

	always_ff @(posedge clk_chipset, posedge reset_sdram) begin
		if (reset_sdram) begin
			mix_sum <= '0;
			mixed   <= '0;
		end else begin
			mix_sum <= fm_wide + psg_mix + spk_term;
			mixed   <= clamped;
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// Out of range sums land on the matching limit one cycle later
	assert property (@(posedge clk_chipset) disable iff (reset_sdram)
		(mix_sum > mix_sum_t'(sample_max) || mix_sum < mix_sum_t'(sample_min))
		|=> mixed == ($past(mix_sum[sum_top]) ? sample_min : sample_max))
	else $error("sample_mixer clamp missed an out of range sum");

endmodule

//--- audio_mix/dynamic_compressor.sv
/*
 * Output dynamic compressor
 * Light and heavy fixed curves on the sample magnitude
 * Bypass passes the mixed sample through the register
 */
module dynamic_compressor
	import audio_pkg::*, audio_cfg_pkg::*;
(
	input  logic          clk_chipset,
	input  logic          reset_sdram,
	input  audio_sample_t mixed,
	input  comp_mode_t    comp_mode,
	output audio_sample_t audio_out
);

	localparam int mag_width = $bits(mix_sum_t);

	// Gain slope below the knee, flatter fall slope above it
	function automatic logic [15:0] curve(
		input logic [mag_width-1:0] mag,
		input logic [15:0]          knee,
		input logic [15:0]          gain,
		input logic [15:0]          fall,
		input logic [15:0]          base
	);
		logic [mag_width-1:0] result;
		if (mag < mag_width'(knee)) begin
			result = mag * gain;
		end else begin
			result = (mag - knee) / fall + base;
		end
		// Top of the curve can pass full scale
		if (result > mag_width'(sample_max)) begin
			result = mag_width'(sample_max);
		end
		return result[15:0];
	endfunction

	mix_sum_t             mixed_wide;
	logic [mag_width-1:0] mag;
	logic [15:0]          light_mag;
	logic [15:0]          heavy_mag;
	logic [15:0]          curve_mag;
	audio_sample_t        shaped;

	// Magnitude in 17 bits so that full negative scale fits
	assign mixed_wide = mix_sum_t'(mixed);
	assign mag        = mixed[15] ? -mixed_wide : mixed_wide;

	assign light_mag = curve(mag, comp_light_knee, comp_light_gain,
		comp_light_fall, comp_light_base);
	assign heavy_mag = curve(mag, comp_heavy_knee, comp_heavy_gain,
		comp_heavy_fall, comp_heavy_base);

	assign curve_mag = (comp_mode == comp_light) ? light_mag : heavy_mag;

	// Restore the sign
	assign shaped = mixed[15] ? -audio_sample_t'(curve_mag) : audio_sample_t'(curve_mag);

	always_ff @(posedge clk_chipset, posedge reset_sdram) begin
		if (reset_sdram) begin
			audio_out <= '0;
		end else if (comp_mode == comp_bypass) begin
			audio_out <= mixed;
		end else begin
			audio_out <= shaped;
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// Compressed magnitude stays within 32767, so never the negative limit
	assert property (@(posedge clk_chipset) disable iff (reset_sdram)
		comp_mode != comp_bypass |=> audio_out != sample_min)
	else $error("dynamic_compressor output magnitude above 32767");

endmodule

//--- hdl/audio_top.sv
/*
 * Mono audio path top level
 * FM and Tandy conditioning side by side
 * Mixer and compressor on the combined result
 */
module audio_top
	import audio_pkg::*, audio_cfg_pkg::*;
#(
	parameter int PSG_BASE_SHIFT = 4,
	parameter int SPK_BASE_LEVEL = 2048
) (
	input  logic          clk_chipset,
	input  logic          reset_sdram,
	input  fm_sample_t    fm_sample,
	input  psg_code_t     psg_code,
	input  volume_t       psg_volume,
	input  logic          speaker,
	input  volume_t       spk_volume,
	input  comp_mode_t    comp_mode,
	output audio_sample_t audio_out
);

	fm_sample_t    fm_stable;
	mix_sum_t      psg_mix;
	audio_sample_t mixed;

	//////////////////////////////////////////////////
	// Source conditioning
	//////////////////////////////////////////////////

	// FM sample crosses from the synthesizer clock
	sample_sync #(
		.sample_t (fm_sample_t)
	) fm_sync (
		.clk_chipset (clk_chipset),
		.reset_sdram (reset_sdram),
		.sample_in   (fm_sample),
		.sample_out  (fm_stable)
	);

	psg_level #(
		.PSG_BASE_SHIFT (PSG_BASE_SHIFT)
	) psg_level (
		.clk_chipset (clk_chipset),
		.reset_sdram (reset_sdram),
		.psg_code    (psg_code),
		.psg_volume  (psg_volume),
		.psg_mix     (psg_mix)
	);

	//////////////////////////////////////////////////
	// Mix and compress
	//////////////////////////////////////////////////

	sample_mixer #(
		.SPK_BASE_LEVEL (SPK_BASE_LEVEL)
	) sample_mixer (
		.clk_chipset (clk_chipset),
		.reset_sdram (reset_sdram),
		.fm_sample   (fm_stable),
		.psg_mix     (psg_mix),
		.speaker     (speaker),
		.spk_volume  (spk_volume),
		.mixed       (mixed)
	);

	// Single mono output
	dynamic_compressor dynamic_compressor (
		.clk_chipset (clk_chipset),
		.reset_sdram (reset_sdram),
		.mixed       (mixed),
		.comp_mode   (comp_mode),
		.audio_out   (audio_out)
	);

endmodule

//--- dv/audio_tb.sv
/*
 * Testbench for the mono audio path
 * Clock, reset, vector playback from the vector file
 * Sample compare task and cycle timeout
 */
module audio_tb
	import audio_pkg::*, audio_cfg_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int reset_cycles  = 10;
	localparam int hold_cycles   = 12;
	localparam int glitch_cycles = 6;
	localparam int max_vectors   = 64;

	// Word positions within one vector line
	localparam int fields   = 8;
	localparam int f_fm     = 0;
	localparam int f_psg    = 1;
	localparam int f_pvol   = 2;
	localparam int f_spk    = 3;
	localparam int f_svol   = 4;
	localparam int f_mode   = 5;
	localparam int f_expect = 6;
	localparam int f_glitch = 7;

	logic          clk_chipset;
	logic          reset_sdram;
	fm_sample_t    fm_sample;
	psg_code_t     psg_code;
	volume_t       psg_volume;
	logic          speaker;
	volume_t       spk_volume;
	comp_mode_t    comp_mode;
	audio_sample_t audio_out;

	logic [15:0] vec_mem [0:max_vectors*fields-1];
	int          num_vectors;
	int          cycle_limit = 0;
	int          cycle_count = 0;

	audio_top dut (
		.clk_chipset (clk_chipset),
		.reset_sdram (reset_sdram),
		.fm_sample   (fm_sample),
		.psg_code    (psg_code),
		.psg_volume  (psg_volume),
		.speaker     (speaker),
		.spk_volume  (spk_volume),
		.comp_mode   (comp_mode),
		.audio_out   (audio_out)
	);

	initial begin
		clk_chipset = 1'b0;
		forever #4 clk_chipset = ~clk_chipset;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic check_sample(input string where, input audio_sample_t expected,
		input audio_sample_t actual);
		if (actual !== expected) begin
			$display("** Error audio_out (%s): expected 16'h%h, got 16'h%h",
				where, expected, actual);
			$display("Done: errors found");
			$fatal(1, "audio_out mismatch");
		end
	endtask

	// FM only in bypass, so a leaked complement would show up unchanged
	task automatic verify_no_leak(input fm_sample_t leaked);
		if (comp_mode == comp_bypass && psg_code == '0 && speaker &&
			audio_out === audio_sample_t'(leaked)) begin
			$display("** Error audio_out: glitch value 16'h%h reached the output",
				leaked);
			$display("Done: errors found");
			$fatal(1, "Glitching FM sample passed the stability filter");
		end
	endtask

	// Glitch words outside 0 and 1 mark the end of the file
	task automatic load_vectors();
		for (int i = 0; i < max_vectors * fields; i++) begin
			vec_mem[i] = 16'hF000 | 16'(i);
		end
		$readmemh("dv/audio_vectors.txt", vec_mem);
		num_vectors = 0;
		while (num_vectors < max_vectors &&
			vec_mem[num_vectors * fields + f_glitch] <= 16'd1) begin
			num_vectors++;
		end
	endtask

	function automatic int total_cycles();
		int total;
		total = reset_cycles + 1;
		for (int i = 0; i < num_vectors; i++) begin
			total += hold_cycles;
			if (vec_mem[i * fields + f_glitch][0]) begin
				total += glitch_cycles;
			end
		end
		return total;
	endfunction

	task automatic play_vector(input int idx);
		int            base;
		fm_sample_t    value;
		audio_sample_t expected;
		logic          glitch;
		base     = idx * fields;
		value    = fm_sample_t'(vec_mem[base + f_fm]);
		expected = audio_sample_t'(vec_mem[base + f_expect]);
		glitch   = vec_mem[base + f_glitch][0];
		@(negedge clk_chipset);
		psg_code   = vec_mem[base + f_psg][7:0];
		psg_volume = vec_mem[base + f_pvol][1:0];
		speaker    = vec_mem[base + f_spk][0];
		spk_volume = vec_mem[base + f_svol][1:0];
		comp_mode  = vec_mem[base + f_mode][1:0];
		// FM toggles against its complement, as a sample caught mid-change
		if (glitch) begin
			for (int k = 0; k < glitch_cycles; k++) begin
				fm_sample = (k % 2 == 0) ? value : ~value;
				@(negedge clk_chipset);
				verify_no_leak(~value);
			end
		end
		fm_sample = value;
		for (int k = 0; k < hold_cycles - 1; k++) begin
			@(negedge clk_chipset);
			if (glitch) begin
				verify_no_leak(~value);
			end
		end
		check_sample($sformatf("vector %0d", idx), expected, audio_out);
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		reset_sdram = 1'b1;
		fm_sample   = '0;
		psg_code    = '0;
		psg_volume  = '0;
		speaker     = 1'b1;
		spk_volume  = '0;
		comp_mode   = comp_bypass;

		load_vectors();
		if (num_vectors == 0) begin
			$display("Done: errors found");
			$fatal(1, "No vectors could be read from dv/audio_vectors.txt");
		end
		cycle_limit = 10 * total_cycles();

		repeat (reset_cycles) begin
			@(negedge clk_chipset);
			check_sample("in reset", '0, audio_out);
		end
		reset_sdram = 1'b0;
		@(negedge clk_chipset);
		check_sample("after reset", '0, audio_out);

		for (int i = 0; i < num_vectors; i++) begin
			play_vector(i);
		end

		$display("Done: no errors");
		$finish;
	end

	// Stops a run that never reaches the end of the vectors
	always @(posedge clk_chipset) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Done: errors found");
			$fatal(1, "Timeout: vectors not finished after %0d cycles", cycle_count);
		end
	end

endmodule

//--- all.f
// Packages first, then the blocks bottom-up, testbench last
common/audio_pkg.sv
common/audio_cfg_pkg.sv
audio_in/sample_sync.sv
audio_in/psg_level.sv
audio_mix/sample_mixer.sv
audio_mix/dynamic_compressor.sv
hdl/audio_top.sv
dv/audio_tb.sv

//--- Makefile
# Verilator build and run of the audio path testbench

OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build audio_tb with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

# The binary exits non-zero when the testbench calls \$$fatal
test:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module audio_tb --Mdir $(OBJ_DIR) -o audio_tb -f all.f
	./$(OBJ_DIR)/audio_tb

clean:
	rm -rf $(OBJ_DIR)

//--- dv/audio_vectors.txt
// fm_sample psg_code psg_volume speaker spk_volume comp_mode expected_audio_out glitch
// FM only, bypass; glitch lines toggle fm against its complement first
04D2 00 0 1 0 0 04D2 0
FB2E 00 0 1 0 0 FB2E 0
7FFF 00 0 1 0 0 7FFF 0
8000 00 0 1 0 0 8000 0
5A5A 00 0 1 0 0 5A5A 1
C3C3 00 0 1 0 0 C3C3 1
0000 00 0 1 0 0 0000 0
// Tandy level shifted by 4 plus volume
0000 01 0 1 0 0 0010 0
0000 FF 0 1 0 0 0FF0 0
0000 FF 1 1 0 0 1FE0 0
0000 FF 2 1 0 0 3FC0 0
0000 FF 3 1 0 0 7F80 0
0000 5A 3 1 0 0 2D00 0
0000 A5 1 1 0 0 14A0 0
// Speaker active low, 2048 shifted by volume
0000 00 0 0 0 0 0800 0
0000 00 0 0 1 0 1000 0
0000 00 0 0 2 0 2000 0
0000 00 0 0 3 0 4000 0
0000 00 0 1 3 0 0000 0
0100 10 0 0 0 0 0A00 0
// Clamp, lowest reachable sum is the FM minimum since the other sources add
7000 FF 3 1 0 0 7FFF 0
7FFF 00 0 0 3 0 7FFF 0
4000 80 3 1 0 0 7FFF 0
8000 FF 3 1 0 0 FF80 0
// Light curve, knee 14044, base 28088
1000 00 0 1 0 1 2000 0
5000 00 0 1 0 1 7401 0
F000 00 0 1 0 1 E000 0
B000 00 0 1 0 1 8BFF 0
36DC 00 0 1 0 1 6DB8 0
36DB 00 0 1 0 1 6DB6 0
// Heavy curve, knee 7400, base 29600
0400 00 0 1 0 3 1000 0
6000 00 0 1 0 3 7C03 0
C000 00 0 1 0 3 87FD 0
FC00 00 0 1 0 3 F000 0
1CE8 00 0 1 0 3 73A0 0
0400 00 0 1 0 2 1000 0
// Mixed sources through the compressor
0000 40 0 0 0 1 1800 0
2000 00 0 1 0 1 4000 1
0000 00 0 1 0 0 0000 0
